/* common/fetchPkg.sv */
// Shared definitions for the instruction fetch stage
// Instruction field positions, opcode constants and the NOP word
// Packed structs describing the fetched word and each later stage
`default_nettype none

package fetchPkg;

   // Later pipeline stages tracked by the hazard unit (D, X, M, W)
   localparam int numStages = 4;
   localparam int regIdxBits = 3;

   // Instruction field positions
   localparam int opMsb = 15;
   localparam int opLsb = 11;
   localparam int rsMsb = 10;
   localparam int rsLsb = 8;
   localparam int rtMsb = 7;
   localparam int rtLsb = 5;

   // Opcodes that matter to fetch
   localparam logic [4:0] opHalt = 5'b00000;
   localparam logic [4:0] opNop = 5'b00001;
   // Any opcode with these upper three bits is a branch
   localparam logic [2:0] opBranchPrefix = 3'b011;

   // Word fed down the pipe while fetch is stalled
   localparam logic [15:0] nopWord = {opNop, 11'b0};

   // Write and branch status of one later stage
   typedef struct packed {
      logic                  regWrt;
      logic [regIdxBits-1:0] wrtReg;
      logic                  branchInst;
   } stageInfo_t;

   // Source registers read by the fetched word
   typedef struct packed {
      logic                  readsRs;
      logic [regIdxBits-1:0] rs;
      logic                  readsRt;
      logic [regIdxBits-1:0] rt;
      logic                  isBranch;
   } srcInfo_t;

endpackage

`default_nettype wire

/* hdl/pcUnit.sv */
// Program counter register with its incrementer
// Raises err on incrementer carry out or a misaligned PC
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic [15:0] newPC,
   input  wire logic        hold,
   input  wire logic        createDump,
   output logic      [15:0] pc,
   output logic      [15:0] incPC,
   output logic             err
);

   logic [16:0] sumWide;
   logic        pcWrite;
   logic        carryOut;
   logic        misaligned;

   // The PC only moves when neither the hazard unit nor a dump freezes it
   assign pcWrite = !hold && !createDump;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= 16'h0000;
      end else if (pcWrite) begin
         pc <= newPC;
      end
   end

   // Keep the carry so that FFFE + 2 is caught
   assign sumWide = {1'b0, pc} + 17'd2;
   assign incPC = sumWide[15:0];
   assign carryOut = sumWide[16];

   // Instructions are word aligned, so an odd PC is an error
   assign misaligned = pc[0];

   assign err = carryOut || misaligned;

   // An even target below FFFE leaves the PC aligned and the incrementer without carry
   evenWriteKeepsAlignment: assert property (
      @(posedge clk) disable iff (rst)
      (pcWrite && !newPC[0] && newPC != 16'hFFFE) |=> !err
   ) else $error("err set after writing an even newPC below FFFE");

endmodule

`default_nettype wire

/* hdl/instrMemory.sv */
// Word-organized instruction memory
// Combinational read by byte address, synchronous word load port
`timescale 1ns/1ps
`default_nettype none

module instrMemory #(
   parameter int memAddrBits = 8
) (
   input  wire logic                   clk,
   input  wire logic [15:0]            addr,
   output logic      [15:0]            rdata,
   input  wire logic                   loadEn,
   input  wire logic [memAddrBits-1:0] loadAddr,
   input  wire logic [15:0]            loadData
);

   localparam int depth = 2 ** memAddrBits;

   logic [15:0] mem [depth];
   logic [memAddrBits-1:0] wordIdx;

   // The byte address becomes a word index and the bits above the array size wrap
   assign wordIdx = addr[memAddrBits:1];

   assign rdata = mem[wordIdx];

   // A load port write is visible to the read side from the next cycle
   always_ff @(posedge clk) begin
      if (loadEn) begin
         mem[loadAddr] <= loadData;
      end
   end

endmodule

`default_nettype wire

/* hazard/srcRegDecode.sv */
// Source register decoder for the fetched word
// Reports which of rs and rt are read and whether the word is a branch
`timescale 1ns/1ps
`default_nettype none

module srcRegDecode (
   input  wire logic [15:0]     instr,
   output fetchPkg::srcInfo_t   src
);

   logic [4:0] opcode;
   logic       isHalt;
   logic       isNop;
   logic       isBranchOp;
   logic       readsNothing;

   assign opcode = instr[fetchPkg::opMsb:fetchPkg::opLsb];

   assign isHalt = (opcode == fetchPkg::opHalt);
   assign isNop = (opcode == fetchPkg::opNop);
   assign isBranchOp = (opcode[4:2] == fetchPkg::opBranchPrefix);

   // Halt and NOP touch no registers
   assign readsNothing = isHalt || isNop;

   always_comb begin
      // Register fields are passed through and the read flags qualify them
      src.rs = instr[fetchPkg::rsMsb:fetchPkg::rsLsb];
      src.rt = instr[fetchPkg::rtMsb:fetchPkg::rtLsb];
      src.isBranch = 1'b0;
      src.readsRs = 1'b0;
      src.readsRt = 1'b0;

      if (readsNothing) begin
         src.readsRs = 1'b0;
         src.readsRt = 1'b0;
      end else if (isBranchOp) begin
         // Branches compare rs only
         src.readsRs = 1'b1;
         src.isBranch = 1'b1;
      end else begin
         src.readsRs = 1'b1;
         src.readsRt = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hazard/stageConflict.sv */
// Conflict check between the fetched word and one later stage
// Flags a pending write to a read register or an unresolved branch
`timescale 1ns/1ps
`default_nettype none

module stageConflict (
   input  wire fetchPkg::srcInfo_t   src,
   input  wire fetchPkg::stageInfo_t stage,
   output logic                      conflict
);

   logic rsHit;
   logic rtHit;
   logic regHazard;

   // Match only registers the fetched word actually reads
   assign rsHit = src.readsRs && (src.rs == stage.wrtReg);
   assign rtHit = src.readsRt && (src.rt == stage.wrtReg);

   assign regHazard = stage.regWrt && (rsHit || rtHit);

   // A branch in flight leaves the fetch path unresolved
   assign conflict = regHazard || stage.branchInst;

endmodule

`default_nettype wire

/* hazard/stallControl.sv */
// Stall controller for the fetch stage
// Merges per-stage conflicts into stall, NOP substitution and valid flags
`timescale 1ns/1ps
`default_nettype none

module stallControl (
   input  wire logic [fetchPkg::numStages-1:0] conflicts,
   input  wire logic [15:0]                    rawInstr,
   input  wire fetchPkg::srcInfo_t             src,
   output logic                                stall,
   output logic      [15:0]                    instruction,
   output logic                                instrValid,
   output logic                                branchInstF
);

   // Any stage in conflict holds the whole fetch
   assign stall = |conflicts;

   always_comb begin
      if (stall) begin
         // Bubble goes down the pipe in place of the fetched word
         instruction = fetchPkg::nopWord;
         instrValid = 1'b0;
      end else begin
         instruction = rawInstr;
         instrValid = 1'b1;
      end
   end

   // A stalled branch is refetched later and reported then
   assign branchInstF = src.isBranch && !stall;

endmodule

`default_nettype wire

/* hdl/fetchStage.sv */
// Top level of the instruction fetch stage
// Connects the PC unit, the instruction memory and the hazard unit
// One stage comparator per later pipeline stage feeds the stall controller
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
   parameter int memAddrBits = 8
) (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic [15:0]            newPC,
   input  wire logic                   createDump,
   input  wire fetchPkg::stageInfo_t   stages [fetchPkg::numStages],
   input  wire logic                   loadEn,
   input  wire logic [memAddrBits-1:0] loadAddr,
   input  wire logic [15:0]            loadData,
   output logic      [15:0]            instruction,
   output logic      [15:0]            incPC,
   output logic                        instrValid,
   output logic                        branchInstF,
   output logic                        err
);

   logic [15:0]                    pc;
   logic [15:0]                    rawInstr;
   logic                           stall;
   logic [fetchPkg::numStages-1:0] conflicts;
   fetchPkg::srcInfo_t             src;

   pcUnit pcUnit0 (
      .clk(clk),
      .rst(rst),
      .newPC(newPC),
      .hold(stall),
      .createDump(createDump),
      .pc(pc),
      .incPC(incPC),
      .err(err)
   );

   instrMemory #(.memAddrBits(memAddrBits)) instrMemory0 (
      .clk(clk),
      .addr(pc),
      .rdata(rawInstr),
      .loadEn(loadEn),
      .loadAddr(loadAddr),
      .loadData(loadData)
   );

   srcRegDecode srcRegDecode0 (.instr(rawInstr), .src(src));

   // Index 0 is decode and the last index is writeback
   for (genvar k = 0; k < fetchPkg::numStages; k++) begin : gStage
      stageConflict stageConflict0 (.src(src), .stage(stages[k]), .conflict(conflicts[k]));
   end

   stallControl stallControl0 (
      .conflicts(conflicts),
      .rawInstr(rawInstr),
      .src(src),
      .stall(stall),
      .instruction(instruction),
      .instrValid(instrValid),
      .branchInstF(branchInstF)
   );

   // A bubble cycle must leave the PC where it was, so the word is refetched
   bubbleHoldsPc: assert property (
      @(posedge clk) disable iff (rst)
      !instrValid |=> pc == $past(pc)
   ) else $error("PC moved during a stall");

endmodule

`default_nettype wire

/* verification/fetchStageTb.sv */
// Testbench for the instruction fetch stage
// Loads a program under reset, then applies a table of next PCs and later-stage states
// Expected outputs come from a model memory, a model PC and the hazard rules
`timescale 1ns/1ps
`default_nettype none

module fetchStageTb;

   localparam int memAddrBits = 8;
   localparam int numRows = 30;
   localparam int fixedWords = 8;
   localparam int loadLen = 17;
   localparam int resetCycles = 4;
   localparam int cycleLimit = numRows + loadLen + resetCycles + 20;

   // Each table row holds a next PC or follows the model incPC, plus a dump flag and stages D to W
   typedef struct packed {
      logic [15:0]                newPC;
      logic                       follow;
      logic                       dump;
      fetchPkg::stageInfo_t [3:0] st;
   } tableRow_t;

   logic                   clk;
   logic                   rst;
   logic [15:0]            newPC;
   logic                   createDump;
   fetchPkg::stageInfo_t   stages [fetchPkg::numStages];
   logic                   loadEn;
   logic [memAddrBits-1:0] loadAddr;
   logic [15:0]            loadData;
   logic [15:0]            instruction;
   logic [15:0]            incPC;
   logic                   instrValid;
   logic                   branchInstF;
   logic                   err;

   tableRow_t            rows [numRows];
   logic [15:0]          modelMem [2**memAddrBits];
   logic [15:0]          modelPc;
   logic [31:0]          lcgState;
   int                   errorCount;
   int                   checkCount;
   int                   cycleCount = 0;
   fetchPkg::stageInfo_t quiet;
   fetchPkg::stageInfo_t branchSt;

   // Hand-written start of the program at indices 0 to 7
   logic [15:0] fixedProg [fixedWords] = '{
      16'h2140, 16'h2B80, 16'h6500, 16'h0800,
      16'h86E0, 16'h0000, 16'hC220, 16'h7860
   };

   fetchStage #(.memAddrBits(memAddrBits)) dut0 (
      .clk(clk),
      .rst(rst),
      .newPC(newPC),
      .createDump(createDump),
      .stages(stages),
      .loadEn(loadEn),
      .loadAddr(loadAddr),
      .loadData(loadData),
      .instruction(instruction),
      .incPC(incPC),
      .instrValid(instrValid),
      .branchInstF(branchInstF),
      .err(err)
   );

   initial begin
      clk = 1'b0;
   end

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout: the test did not finish within %0d clock cycles", cycleLimit);
         $display("Regression failed");
         $finish;
      end
   end

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic fetchPkg::stageInfo_t makeStage(input logic wrt, input logic [2:0] r,
                                                      input logic br);
      fetchPkg::stageInfo_t s;
      s.regWrt = wrt;
      s.wrtReg = r;
      s.branchInst = br;
      return s;
   endfunction

   function automatic fetchPkg::stageInfo_t writesReg(input logic [2:0] r);
      return makeStage(1'b1, r, 1'b0);
   endfunction

   function automatic logic isBranchWord(input logic [15:0] w);
      return w[15:13] == 3'b011;
   endfunction

   // Halt and NOP read nothing, branches read rs only, all else reads rs and rt
   function automatic logic stallFor(input logic [15:0] w, input fetchPkg::stageInfo_t [3:0] st);
      logic readsRs;
      logic readsRt;
      logic hit;
      readsRs = (w[15:11] != 5'b00000) && (w[15:11] != 5'b00001);
      readsRt = readsRs && !isBranchWord(w);
      hit = 1'b0;
      for (int k = 0; k < 4; k++) begin
         if (st[k].branchInst
               || (st[k].regWrt && readsRs && st[k].wrtReg == w[10:8])
               || (st[k].regWrt && readsRt && st[k].wrtReg == w[7:5])) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   task automatic checkValue(input string what, input int row, input logic [15:0] got,
                             input logic [15:0] exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("error at %0t ns: row %0d %s is %h, expected %h", $time, row, what, got, exp);
      end
   endtask

   task automatic setRow(input int i, input logic [15:0] pc, input logic follow, input logic dump,
                         input fetchPkg::stageInfo_t d, x, m, w);
      rows[i].newPC = pc;
      rows[i].follow = follow;
      rows[i].dump = dump;
      rows[i].st = {w, m, x, d};
   endtask

   task automatic buildTable();
      // Sequential fetch from word 0
      setRow(0, 16'h0000, 1, 0, quiet, quiet, quiet, quiet);
      setRow(1, 16'h0000, 1, 0, quiet, quiet, quiet, quiet);
      setRow(2, 16'h0000, 1, 0, quiet, quiet, quiet, quiet);
      setRow(3, 16'h0000, 1, 0, quiet, quiet, quiet, quiet);
      setRow(4, 16'h0000, 0, 0, quiet, quiet, quiet, quiet);
      // Register hazards on rs and rt, then writes that miss
      setRow(5, 16'h0000, 1, 0, quiet, writesReg(2), quiet, quiet);
      setRow(6, 16'h0000, 1, 0, quiet, quiet, writesReg(1), quiet);
      setRow(7, 16'h0000, 1, 0, makeStage(0, 1, 0), quiet, quiet, writesReg(5));
      setRow(8, 16'h0000, 1, 0, writesReg(4), quiet, quiet, quiet);
      setRow(9, 16'h0000, 1, 0, quiet, quiet, quiet, quiet);
      // The branch word reads rs only
      setRow(10, 16'h0000, 1, 0, writesReg(5), quiet, quiet, quiet);
      setRow(11, 16'h0000, 1, 0, quiet, quiet, quiet, writesReg(0));
      // Branches in later stages
      setRow(12, 16'h0000, 1, 0, quiet, branchSt, quiet, quiet);
      setRow(13, 16'h0000, 1, 0, quiet, quiet, quiet, branchSt);
      setRow(14, 16'h0000, 1, 0, writesReg(0), quiet, quiet, quiet);
      // Dump freeze once alone and once with a hazard
      setRow(15, 16'h0000, 1, 1, quiet, quiet, quiet, quiet);
      setRow(16, 16'h0000, 1, 1, quiet, quiet, writesReg(6), quiet);
      setRow(17, 16'h0000, 1, 0, quiet, quiet, quiet, quiet);
      setRow(18, 16'h0000, 1, 0, writesReg(0), quiet, quiet, quiet);
      setRow(19, 16'h0000, 1, 0, quiet, writesReg(1), quiet, quiet);
      setRow(20, 16'h0000, 1, 0, quiet, quiet, quiet, quiet);
      // Overflow, odd PC and redirects that wrap the word index
      setRow(21, 16'hFFFE, 0, 0, quiet, quiet, quiet, quiet);
      setRow(22, 16'h0005, 0, 0, quiet, quiet, quiet, quiet);
      setRow(23, 16'h0204, 0, 0, quiet, quiet, quiet, quiet);
      setRow(24, 16'h1E1C, 0, 0, quiet, quiet, quiet, quiet);
      setRow(25, 16'h0016, 0, 0, quiet, quiet, quiet, quiet);
      setRow(26, 16'h0000, 1, 0, quiet, quiet, quiet, quiet);
      setRow(27, 16'h0000, 1, 0, quiet, quiet, quiet, quiet);
      setRow(28, 16'h0000, 1, 0, writesReg(3), writesReg(6), quiet, quiet);
      setRow(29, 16'h0000, 1, 0, quiet, quiet, quiet, quiet);
   endtask

   task automatic loadProgram();
      logic [15:0]            word;
      logic [memAddrBits-1:0] addr;
      for (int i = 0; i < loadLen; i++) begin
         if (i < fixedWords) begin
            word = fixedProg[i];
         end else begin
            lcgState = lcgNext(lcgState);
            word = lcgState[31:16];
         end
         // The last word goes to the top index, where a fetch at FFFE lands
         addr = (i == loadLen - 1) ? '1 : memAddrBits'(i);
         @(posedge clk);
         #2;
         loadEn = 1'b1;
         loadAddr = addr;
         loadData = word;
         modelMem[addr] = word;
      end
      @(posedge clk);
      #2;
      loadEn = 1'b0;
   endtask

   task automatic runTable();
      tableRow_t   row;
      logic [15:0] word;
      logic        stallExp;
      for (int r = 0; r < numRows; r++) begin
         row = rows[r];
         @(posedge clk);
         #2;
         newPC = row.follow ? modelPc + 16'd2 : row.newPC;
         createDump = row.dump;
         for (int k = 0; k < fetchPkg::numStages; k++) begin
            stages[k] = row.st[k];
         end
         #36;
         word = modelMem[modelPc[memAddrBits:1]];
         stallExp = stallFor(word, row.st);
         checkValue("instruction", r, instruction, stallExp ? 16'h0800 : word);
         checkValue("incPC", r, incPC, modelPc + 16'd2);
         checkValue("instrValid", r, instrValid, !stallExp);
         checkValue("branchInstF", r, branchInstF, isBranchWord(word) && !stallExp);
         checkValue("err", r, err, (modelPc > 16'hFFFD) || modelPc[0]);
         // The PC moves at the coming edge unless frozen
         if (!row.dump && !stallExp) begin
            modelPc = newPC;
         end
      end
   endtask

   initial begin
      rst = 1'b1;
      newPC = 16'h0000;
      createDump = 1'b0;
      loadEn = 1'b0;
      loadAddr = '0;
      loadData = 16'h0000;
      for (int k = 0; k < fetchPkg::numStages; k++) begin
         stages[k] = '0;
      end
      errorCount = 0;
      checkCount = 0;
      modelPc = 16'h0000;
      lcgState = 32'd70502;
      quiet = makeStage(1'b0, 3'd0, 1'b0);
      branchSt = makeStage(1'b0, 3'd0, 1'b1);
      buildTable();
      // Program load runs under reset, then reset stays high four more cycles
      loadProgram();
      repeat (resetCycles) @(posedge clk);
      #2;
      rst = 1'b0;
      runTable();
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
common/fetchPkg.sv
hdl/pcUnit.sv
hdl/instrMemory.sv
hazard/srcRegDecode.sv
hazard/stageConflict.sv
hazard/stallControl.sv
hdl/fetchStage.sv
verification/fetchStageTb.sv

/* Bender.yml */
package:
  name: fetch_stage

dependencies: {}

sources:
  # Shared package first, then leaf modules, then the top level
  - files:
      - common/fetchPkg.sv
      - hdl/pcUnit.sv
      - hdl/instrMemory.sv
      - hazard/srcRegDecode.sv
      - hazard/stageConflict.sv
      - hazard/stallControl.sv
      - hdl/fetchStage.sv

  # Testbench, only for simulation
  - target: simulation
    files:
      - verification/fetchStageTb.sv
